/* src/exec_cfg.svh */
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

`define EXE_XLEN	16	// data word width
`define EXE_NREGS	16
`define EXE_MULREG	7	// reads high product or remainder
`define EXE_BYTE	8

// byte lanes per word
`define EXE_LANES	(`EXE_XLEN / `EXE_BYTE)

`endif

/* src/exec_pkg.sv */
`include "exec_cfg.svh"

package exec_pkg;

	typedef logic [`EXE_XLEN-1:0] word_t;
	typedef logic [`EXE_XLEN-2:0] pc_t;	// halfword address
	typedef logic [$clog2(`EXE_NREGS)-1:0] reg_idx_t;
	typedef logic [`EXE_LANES-1:0] lane_t;

	typedef enum logic [3:0] {
		op_add   = 4'd0,
		op_sub   = 4'd1,
		op_xor   = 4'd2,
		op_or    = 4'd3,
		op_and   = 4'd4,
		op_sll   = 4'd5,
		op_sra   = 4'd6,
		op_srl   = 4'd7,
		op_addb  = 4'd8,
		op_addbu = 4'd9,
		op_swap  = 4'd10
	} alu_op_t;

	// bit 0 is link for jumps, byte access for loads and stores
	typedef enum logic [2:0] {
		cond_eqz    = 3'b000,
		cond_nez    = 3'b001,
		cond_gez    = 3'b010,
		cond_ltz    = 3'b011,
		cond_always = 3'b100
	} cond_t;

	typedef enum logic [1:0] {md_idle, md_mult, md_div} md_state_t;

	typedef struct packed {
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		logic     needs_rs2;
		word_t    imm;
		alu_op_t  op;
		cond_t    cond;
		logic     br, jmp, load, store, set_cc, mult, div;
	} instr_t;

	typedef struct packed {
		word_t addr;
		word_t wdata;
		lane_t wmask;
		lane_t rstrobe;
	} mem_req_t;

endpackage

/* src/exec_alu.sv */
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_alu (
	input  exec_pkg::word_t   a,
	input  exec_pkg::word_t   b,
	input  exec_pkg::alu_op_t op,
	output exec_pkg::word_t   result,
	output logic              carry
);
	import exec_pkg::*;

	localparam int XL  = `EXE_XLEN;
	localparam int BW  = `EXE_BYTE;
	localparam int SHW = $clog2(`EXE_XLEN);

	logic [XL:0]    added;
	logic [XL:0]    subbed;
	logic [SHW-1:0] shamt;

	assign added  = {1'b0, a} + {1'b0, b};
	assign subbed = {1'b0, a} - {1'b0, b};
	assign shamt  = b[SHW-1:0];

	// borrow for sub
	assign carry = (op == op_sub) ? subbed[XL] : added[XL];

	always_comb begin
		case (op)
		op_add:   result = added[XL-1:0];
		op_sub:   result = subbed[XL-1:0];
		op_xor:   result = a ^ b;
		op_or:    result = a | b;
		op_and:   result = a & b;
		op_sll:   result = a << shamt;
		op_sra:   result = word_t'($signed(a) >>> shamt);
		op_srl:   result = a >> shamt;
		op_addb:  result = {{(XL-BW){added[BW-1]}}, added[BW-1:0]};
		op_addbu: result = {{(XL-BW){1'b0}}, added[BW-1:0]};
		op_swap:  result = {b[BW-1:0], b[XL-1:BW]};
		default:  result = '0;
		endcase
	end

endmodule

/* src/exec_regfile.sv */
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_regfile (
	input  logic              clk,
	input  logic              reset,
	input  exec_pkg::reg_idx_t rs1,
	input  exec_pkg::reg_idx_t rs2,
	input  logic              wb_valid,
	input  exec_pkg::reg_idx_t wb_addr,
	input  exec_pkg::word_t   wb_data,
	input  exec_pkg::word_t   mul_hi,
	output exec_pkg::word_t   rdata1,
	output exec_pkg::word_t   rdata2
);
	import exec_pkg::*;

	localparam reg_idx_t MULREG = reg_idx_t'(`EXE_MULREG);

	word_t regs [`EXE_NREGS];	// entries 0 and 7 never written

	function automatic word_t read_port(reg_idx_t idx);
		word_t val;
		if (wb_valid && wb_addr == idx && idx != '0) begin
			val = wb_data;	// pending write-back
		end else if (idx == '0) begin
			val = '0;
		end else if (idx == MULREG) begin
			val = mul_hi;
		end else begin
			val = regs[idx];
		end
		return val;
	endfunction

	always_comb begin
		rdata1 = read_port(rs1);
	end

	always_comb begin
		rdata2 = read_port(rs2);
	end

	// r7 lives in the muldiv unit
	always_ff @(posedge clk) begin
		if (!reset && wb_valid && wb_addr != '0 && wb_addr != MULREG) begin
			regs[wb_addr] <= wb_data;
		end
	end

endmodule

/* src/exec_muldiv.sv */
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_muldiv (
	input  logic               clk,
	input  logic               reset,
	input  logic               start_mult,
	input  logic               start_div,
	input  exec_pkg::word_t    a,
	input  exec_pkg::word_t    b,
	input  logic               wb_valid,
	input  exec_pkg::reg_idx_t wb_addr,
	input  exec_pkg::word_t    wb_data,
	output logic               busy,
	output logic               done,
	output exec_pkg::word_t    lo,
	output exec_pkg::word_t    hi
);
	import exec_pkg::*;

	localparam int XL = `EXE_XLEN;

	md_state_t             state;
	logic [$clog2(XL)-1:0] count;
	logic [2*XL-1:0]       prod;	// {hi, lo}
	word_t                 a_r, b_r;
	logic [XL:0]           part;
	logic [XL+1:0]         diff;

	assign busy = state != md_idle;
	assign lo   = prod[XL-1:0];
	assign hi   = prod[2*XL-1:XL];

	// remainder with next dividend bit shifted in
	assign part = prod[2*XL-1:XL-1];
	assign diff = {1'b0, part} - {2'b0, b_r};

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= md_idle;
			count <= '0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
			md_idle: begin
				count <= '1;
				if (start_mult) state <= md_mult;
				else if (start_div) state <= md_div;
			end
			default: begin
				count <= count - 1'b1;
				if (count == '0) begin
					state <= md_idle;
					done  <= 1'b1;
				end
			end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start_mult || start_div) begin
			a_r  <= a;
			b_r  <= b;
			prod <= start_mult ? '0 : {{XL{1'b0}}, a};
		end else if (state == md_mult) begin
			prod <= {prod[2*XL-2:0], 1'b0} + (a_r[XL-1] ? {{XL{1'b0}}, b_r} : '0);
			a_r  <= a_r << 1;	// msb first
		end else if (state == md_div) begin
			if (b_r == '0) prod <= '0;	// divide by zero
			else if (!diff[XL+1]) prod <= {diff[XL-1:0], prod[XL-2:0], 1'b1};
			else prod <= {part[XL-1:0], prod[XL-2:0], 1'b0};
		end else if (wb_valid && wb_addr == reg_idx_t'(`EXE_MULREG)) begin
			prod[2*XL-1:XL] <= wb_data;
		end
	end

endmodule

/* src/exec_control.sv */
`timescale 1ns/1ps
`include "exec_cfg.svh"

module exec_control (
	input  logic               clk,
	input  logic               reset,
	input  exec_pkg::instr_t   instr,
	input  logic               iready,
	output logic               accept,
	output exec_pkg::pc_t      pc,
	input  exec_pkg::word_t    rdata1,
	input  exec_pkg::word_t    rdata2,
	output exec_pkg::word_t    operand_b,
	input  exec_pkg::word_t    alu_result,
	input  logic               alu_carry,
	input  logic               md_busy,
	input  logic               md_done,
	input  exec_pkg::word_t    md_lo,
	output logic               start_mult,
	output logic               start_div,
	output logic               wb_valid,
	output exec_pkg::reg_idx_t wb_addr,
	output exec_pkg::word_t    wb_data,
	output exec_pkg::mem_req_t mem,
	input  logic               rdone,
	input  logic               wdone,
	input  exec_pkg::word_t    mem_rdata,
	output logic               carry
);
	import exec_pkg::*;

	localparam int XL = `EXE_XLEN;
	localparam int BW = `EXE_BYTE;

	logic          running, branch_stall, take, taken, redirect, link;
	logic          rd_busy, wr_busy;
	logic [BW-1:0] ld_byte;
	lane_t         lanes;
	pc_t           pc_next;

	assign rd_busy    = |mem.rstrobe;
	assign wr_busy    = |mem.wmask;
	assign accept     = running && !branch_stall && !rd_busy && !wr_busy && !md_busy && !md_done;
	assign take       = accept && iready;
	assign start_mult = take && instr.mult;
	assign start_div  = take && instr.div;
	assign pc_next    = pc + 1'b1;
	assign operand_b  = (instr.needs_rs2 && !instr.load && !instr.store) ? rdata2 : instr.imm;

	always_comb begin
		case (instr.cond)
		cond_eqz: taken = rdata1 == '0;
		cond_nez: taken = rdata1 != '0;
		cond_gez: taken = !rdata1[XL-1];
		cond_ltz: taken = rdata1[XL-1];
		default:  taken = 1'b1;	// always, with or without link
		endcase
	end

	assign redirect = take && (instr.jmp || (instr.br && taken));
	assign link     = (instr.jmp || (instr.br && instr.cond[2])) && instr.cond[0];
	assign lanes    = !instr.cond[0] ? '1 : (alu_result[0] ? 2'b10 : 2'b01);
	assign ld_byte  = mem.rstrobe[1] ? mem_rdata[XL-1:BW] : mem_rdata[BW-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			running      <= 1'b0;
			branch_stall <= 1'b0;
			pc           <= '0;
			carry        <= 1'b0;
		end else begin
			running      <= 1'b1;
			branch_stall <= redirect;	// one dead cycle after redirect
			if (take) pc <= redirect ? alu_result[XL-1:1] : pc_next;
			if (take && instr.set_cc) carry <= alu_carry;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else if (take) begin
			wb_valid <= !(instr.load || instr.store || instr.mult || instr.div) &&
				!((instr.br || instr.jmp) && !link);
			wb_addr  <= instr.rd;	// kept for load and muldiv
			wb_data  <= link ? {pc_next, 1'b0} : alu_result;
		end else if (rd_busy && rdone) begin
			wb_valid <= 1'b1;
			wb_data  <= (mem.rstrobe == '1) ? mem_rdata : {{(XL-BW){ld_byte[BW-1]}}, ld_byte};
		end else if (md_done) begin
			wb_valid <= 1'b1;
			wb_data  <= md_lo;
		end else begin
			wb_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mem.rstrobe <= '0;
			mem.wmask   <= '0;
		end else if (take && (instr.load || instr.store)) begin
			mem.addr    <= alu_result;
			mem.wdata   <= instr.cond[0] ? {`EXE_LANES{rdata2[BW-1:0]}} : rdata2;
			mem.rstrobe <= instr.load ? lanes : '0;
			mem.wmask   <= instr.store ? lanes : '0;
		end else begin
			if (rdone) mem.rstrobe <= '0;
			if (wdone) mem.wmask <= '0;
		end
	end

endmodule

/* src/exec_core.sv */
`timescale 1ns/1ps

module exec_core (
	input  logic               clk,
	input  logic               reset,
	input  exec_pkg::instr_t   instr,
	input  logic               iready,
	output logic               accept,
	output exec_pkg::pc_t      pc,
	output exec_pkg::mem_req_t mem,
	input  logic               rdone,
	input  exec_pkg::word_t    rdata,
	input  logic               wdone,
	output logic               carry
);
	import exec_pkg::*;

	word_t    rdata1, rdata2, operand_b, alu_result, md_lo, md_hi, wb_data;
	logic     alu_carry, md_busy, md_done, start_mult, start_div, wb_valid;
	reg_idx_t wb_addr;

	exec_control u_control (
		.clk(clk), .reset(reset), .instr(instr), .iready(iready),
		.accept(accept), .pc(pc), .rdata1(rdata1), .rdata2(rdata2),
		.operand_b(operand_b), .alu_result(alu_result), .alu_carry(alu_carry),
		.md_busy(md_busy), .md_done(md_done), .md_lo(md_lo),
		.start_mult(start_mult), .start_div(start_div),
		.wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data),
		.mem(mem), .rdone(rdone), .wdone(wdone), .mem_rdata(rdata), .carry(carry)
	);

	exec_regfile u_regfile (
		.clk(clk), .reset(reset), .rs1(instr.rs1), .rs2(instr.rs2),
		.wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data),
		.mul_hi(md_hi), .rdata1(rdata1), .rdata2(rdata2)
	);

	exec_alu u_alu (
		.a(rdata1), .b(operand_b), .op(instr.op), .result(alu_result), .carry(alu_carry)
	);

	exec_muldiv u_muldiv (
		.clk(clk), .reset(reset), .start_mult(start_mult), .start_div(start_div),
		.a(rdata1), .b(operand_b), .wb_valid(wb_valid), .wb_addr(wb_addr),
		.wb_data(wb_data), .busy(md_busy), .done(md_done), .lo(md_lo), .hi(md_hi)
	);

endmodule

/* testbench/exec_core_assertions.sv */
`timescale 1ns/1ps

module exec_core_assertions (
	input logic               clk,
	input logic               reset,
	input logic               accept,
	input exec_pkg::pc_t      pc,
	input exec_pkg::mem_req_t mem,
	input logic               wdone
);
	import exec_pkg::*;

	int failures = 0;	// read by the testbench at the end

	a_one_request: assert property (@(posedge clk) disable iff (reset)
		!(|mem.rstrobe && |mem.wmask))
		else begin
			$error("read and write requests active together");
			failures++;
		end

	a_wmask_hold: assert property (@(posedge clk) disable iff (reset)
		(|mem.wmask && !wdone) |=> mem.wmask == $past(mem.wmask))
		else begin
			$error("write mask changed before wdone");
			failures++;
		end

	// stall without memory traffic
	a_pc_stable: assert property (@(posedge clk) disable iff (reset)
		(!accept && !(|mem.rstrobe) && !(|mem.wmask)) |=> $stable(pc))
		else begin
			$error("pc moved while accept was low");
			failures++;
		end

endmodule

bind exec_core exec_core_assertions u_assertions (
	.clk(clk), .reset(reset), .accept(accept), .pc(pc), .mem(mem), .wdone(wdone)
);

/* testbench/exec_core_tb.sv */
`timescale 1ns/1ps

module exec_core_tb;
	import exec_pkg::*;

	localparam int K_ALU = 0, K_CC = 1, K_BR = 2, K_JMP = 3;
	localparam int K_LD = 4, K_ST = 5, K_MUL = 6, K_DIV = 7;

	logic clk, reset, iready, accept, rdone, wdone, carry;
	instr_t instr;
	pc_t pc;
	mem_req_t mem;
	word_t rdata;

	instr_t prog [$];	// stimulus table
	bit prog_tk [$];	// expected branch taken
	word_t memory [256];
	word_t model_regs [16];
	word_t model_hi;
	mem_req_t exp_reqs [$];	// loads and stores still to reach memory
	mem_req_t req_exp;
	logic model_carry;
	pc_t model_pc;
	logic [31:0] lfsr_state;
	int errors, cycles, limit, waits;

	exec_core dut (
		.clk(clk), .reset(reset), .instr(instr), .iready(iready), .accept(accept),
		.pc(pc), .mem(mem), .rdone(rdone), .rdata(rdata), .wdone(wdone), .carry(carry)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic next_rand_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	task automatic check(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic put(int kind, int rd, int rs1, int rs2, bit nr2, word_t imm,
		alu_op_t op, cond_t cond, bit tk);
		instr_t ins;
		ins = '0;
		ins.rd = rd;
		ins.rs1 = rs1;
		ins.rs2 = rs2;
		ins.needs_rs2 = nr2;
		ins.imm = imm;
		ins.op = op;
		ins.cond = cond;
		ins.set_cc = kind == K_CC;
		ins.br = kind == K_BR;
		ins.jmp = kind == K_JMP;
		ins.load = kind == K_LD;
		ins.store = kind == K_ST;
		ins.mult = kind == K_MUL;
		ins.div = kind == K_DIV;
		prog.push_back(ins);
		prog_tk.push_back(tk);
	endtask

	function automatic word_t rreg(reg_idx_t idx);
		return (idx == 0) ? '0 : (idx == 7) ? model_hi : model_regs[idx];
	endfunction

	function automatic void wreg(reg_idx_t idx, word_t v);
		if (idx == 7) model_hi = v;
		else if (idx != 0) model_regs[idx] = v;
	endfunction

	function automatic word_t ref_alu(alu_op_t op, word_t a, word_t b, output logic c);
		logic [16:0] s, d;
		word_t r;
		s = {1'b0, a} + {1'b0, b};
		d = {1'b0, a} - {1'b0, b};
		c = (op == op_sub) ? d[16] : s[16];	// borrow on sub
		case (op)
		op_add:   r = s[15:0];
		op_sub:   r = d[15:0];
		op_xor:   r = a ^ b;
		op_or:    r = a | b;
		op_and:   r = a & b;
		op_sll:   r = a << b[3:0];
		op_sra:   r = $signed(a) >>> b[3:0];
		op_srl:   r = a >> b[3:0];
		op_addb:  r = {{8{s[7]}}, s[7:0]};
		op_addbu: r = {8'h00, s[7:0]};
		default:  r = {b[7:0], b[15:8]};
		endcase
		return r;
	endfunction

	task automatic run_step(int i);
		instr_t ins;
		word_t a, b, d2, res, md;
		logic c;
		logic [31:0] prod;
		logic [1:0] lanes;
		mem_req_t req;
		pc_t npc, pc_exp;
		bit tk;
		int errs_before;
		ins = prog[i];
		errs_before = errors;
		tk = 1'b0;
		a = rreg(ins.rs1);
		d2 = rreg(ins.rs2);
		b = (ins.needs_rs2 && !ins.load && !ins.store) ? d2 : ins.imm;
		res = ref_alu(ins.op, a, b, c);
		npc = model_pc + 1'b1;
		pc_exp = npc;
		lanes = ins.cond[0] ? (res[0] ? 2'b10 : 2'b01) : 2'b11;
		if (ins.load || ins.store) begin
			req.addr = res;
			req.wdata = ins.cond[0] ? {2{d2[7:0]}} : d2;
			req.wmask = ins.store ? lanes : 2'b00;
			req.rstrobe = ins.load ? lanes : 2'b00;
			exp_reqs.push_back(req);
		end
		instr = ins;
		iready = 1'b1;
		@(negedge clk);
		while (!accept) @(negedge clk);
		@(posedge clk);
		#1 iready = 1'b0;
		if (ins.br || ins.jmp) begin
			case (ins.cond[1:0])
			2'b00: tk = a == 0;
			2'b01: tk = a != 0;
			2'b10: tk = !a[15];
			default: tk = a[15];
			endcase
			tk = tk || ins.jmp || ins.cond[2];
			if (tk) pc_exp = res[15:1];
			if (ins.cond[0] && (ins.jmp || ins.cond[2])) wreg(ins.rd, {npc, 1'b0});
		end else if (ins.load) begin
			md = memory[res[8:1]];
			if (ins.cond[0]) md = res[0] ? {{8{md[15]}}, md[15:8]} : {{8{md[7]}}, md[7:0]};
			wreg(ins.rd, md);
		end else if (ins.mult || ins.div) begin
			prod = ins.mult ? a * b : (b == 0) ? 32'h0 : {word_t'(a % b), word_t'(a / b)};
			model_hi = prod[31:16];
			wreg(ins.rd, prod[15:0]);
		end else if (!ins.store) begin
			wreg(ins.rd, res);
		end
		if (ins.set_cc) model_carry = c;
		model_pc = pc_exp;
		check("pc", pc, pc_exp);
		check("carry", carry, model_carry);
		check("accept", accept, !(tk || ins.load || ins.store || ins.mult || ins.div));
		if (ins.br || ins.jmp) check("branch taken", pc != npc, prog_tk[i]);
		if (tk) begin
			@(posedge clk);
			#1;
			check("accept", accept, 1'b1);	// one dead cycle only
		end
		$display("step %0d pc %h %s", i, pc, (errors == errs_before) ? "ok" : "mismatch");
	endtask

	// memory model with random wait cycles
	always begin
		@(negedge clk);
		if (mem.rstrobe != 0 || mem.wmask != 0) begin
			waits = {next_rand_bit(), next_rand_bit()};
			repeat (waits) @(posedge clk);
			@(posedge clk);
			#1;
			req_exp = '0;
			if (exp_reqs.size() == 0) begin
				$display("memory request issued with no load or store pending");
				errors++;
			end else begin
				req_exp = exp_reqs.pop_front();
			end
			check("mem.addr", mem.addr, req_exp.addr);
			check("mem.rstrobe", mem.rstrobe, req_exp.rstrobe);
			check("mem.wmask", mem.wmask, req_exp.wmask);
			if (mem.rstrobe != 0) begin
				rdone = 1'b1;
				rdata = memory[mem.addr[8:1]];
			end else begin
				wdone = 1'b1;
				check("mem.wdata", mem.wdata, req_exp.wdata);
				if (mem.wmask[0]) memory[mem.addr[8:1]][7:0] = mem.wdata[7:0];
				if (mem.wmask[1]) memory[mem.addr[8:1]][15:8] = mem.wdata[15:8];
			end
			@(posedge clk);
			#1 rdone = 1'b0;
			wdone = 1'b0;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("timeout: the DUT stopped accepting instructions");
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		iready = 1'b0;
		instr = '0;
		rdone = 1'b0;
		wdone = 1'b0;
		rdata = '0;
		lfsr_state = 32'ha2f2;
		errors = 0;
		cycles = 0;
		limit = 0;
		model_pc = '0;
		model_carry = 1'b0;
		model_hi = '0;
		for (int i = 0; i < 256; i++) memory[i] = word_t'(i * 16'h9e37) ^ 16'h4b1d;
		put(K_LD, 3, 0, 0, 0, 16'h10, op_add, cond_eqz, 0);
		put(K_LD, 4, 0, 0, 0, 16'h22, op_add, cond_eqz, 0);
		put(K_LD, 5, 0, 0, 0, 16'h31, op_add, cond_nez, 0);	// odd byte
		put(K_LD, 6, 0, 0, 0, 16'h40, op_add, cond_nez, 0);
		for (int k = 0; k < 11; k++) begin
			put(K_ALU, 8, 3, 6, 1, 0, alu_op_t'(k), cond_eqz, 0);
			put(K_ST, 0, 0, 8, 0, 16'h80, op_add, cond_eqz, 0);
		end
		put(K_ALU, 9, 8, 5, 1, 0, op_add, cond_eqz, 0);	// dependent chain
		put(K_ALU, 10, 9, 6, 1, 0, op_sra, cond_eqz, 0);
		put(K_ST, 0, 0, 10, 0, 16'h82, op_add, cond_eqz, 0);
		put(K_ALU, 11, 0, 0, 0, 16'h100, op_add, cond_eqz, 0);
		put(K_ALU, 12, 0, 0, 0, 16'h1, op_sub, cond_eqz, 0);
		put(K_BR, 0, 0, 0, 0, 16'h300, op_add, cond_eqz, 1);
		put(K_BR, 0, 11, 0, 0, 16'h0, op_add, cond_eqz, 0);
		put(K_BR, 0, 11, 0, 0, 16'h100, op_add, cond_nez, 1);
		put(K_BR, 0, 0, 0, 0, 16'h40, op_add, cond_nez, 0);
		put(K_BR, 0, 11, 0, 0, 16'h0, op_add, cond_gez, 1);
		put(K_BR, 0, 12, 0, 0, 16'h0, op_add, cond_gez, 0);
		put(K_BR, 0, 12, 0, 0, 16'h101, op_add, cond_ltz, 1);
		put(K_BR, 0, 11, 0, 0, 16'h0, op_add, cond_ltz, 0);
		put(K_JMP, 1, 11, 0, 0, 16'h20, op_add, cond_t'(3'b101), 1);
		put(K_ST, 0, 0, 1, 0, 16'h90, op_add, cond_eqz, 0);
		put(K_ST, 0, 0, 3, 0, 16'h51, op_add, cond_nez, 0);
		put(K_ST, 0, 0, 4, 0, 16'h50, op_add, cond_nez, 0);
		put(K_ST, 0, 0, 5, 0, 16'h52, op_add, cond_eqz, 0);
		put(K_ST, 0, 0, 12, 0, 16'h61, op_add, cond_nez, 0);
		put(K_LD, 13, 0, 0, 0, 16'h61, op_add, cond_nez, 0);
		put(K_ST, 0, 0, 13, 0, 16'h62, op_add, cond_eqz, 0);
		put(K_MUL, 8, 3, 4, 1, 0, op_add, cond_eqz, 0);
		put(K_ST, 0, 0, 8, 0, 16'h70, op_add, cond_eqz, 0);
		put(K_ST, 0, 0, 7, 0, 16'h72, op_add, cond_eqz, 0);
		put(K_DIV, 8, 3, 11, 1, 0, op_add, cond_eqz, 0);
		put(K_ST, 0, 0, 8, 0, 16'h74, op_add, cond_eqz, 0);
		put(K_ST, 0, 0, 7, 0, 16'h76, op_add, cond_eqz, 0);
		put(K_DIV, 8, 3, 0, 1, 0, op_add, cond_eqz, 0);	// divide by zero
		put(K_ST, 0, 0, 8, 0, 16'h78, op_add, cond_eqz, 0);
		put(K_ST, 0, 0, 7, 0, 16'h7a, op_add, cond_eqz, 0);
		put(K_CC, 9, 12, 0, 0, 16'h1, op_add, cond_eqz, 0);
		put(K_CC, 9, 0, 0, 0, 16'h1, op_sub, cond_eqz, 0);
		put(K_CC, 9, 11, 0, 0, 16'h1, op_sub, cond_eqz, 0);
		limit = prog.size() * 24 + 10;
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
		for (int i = 0; i < prog.size(); i++) run_step(i);
		repeat (8) @(posedge clk);
		if (exp_reqs.size() != 0) begin
			$display("a load or store never reached the memory interface");
			errors++;
		end
		errors += dut.u_assertions.failures;
		$display("%0d steps run, %0d errors", prog.size(), errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* exec_core.f */
+incdir+src
src/exec_pkg.sv
src/exec_alu.sv
src/exec_regfile.sv
src/exec_muldiv.sv
src/exec_control.sv
src/exec_core.sv
testbench/exec_core_assertions.sv
testbench/exec_core_tb.sv
